// ==== design/pcs_rx_consts.svh ====
// PCS receive status constants for sync header codes, lock rules and BER limits
`ifndef PCS_RX_CONSTS_SVH
`define PCS_RX_CONSTS_SVH

// Sync header width is fixed by the 64b/66b line code
`define PCS_HDR_W 2

// The only two legal sync header patterns
`define PCS_SYNC_DATA 2'b10
`define PCS_SYNC_CTRL 2'b01

// Block lock rules, simplified from clause 49
`define PCS_LOCK_GOOD_CNT 64
`define PCS_LOCK_WINDOW 64
`define PCS_LOCK_BAD_MAX 16

// Invalid headers per timer window that flag a high bit error rate
`define PCS_BER_BAD_MAX 16

// 125 us at 156.25 MHz
`define PCS_BER_WINDOW_DEFAULT 19531

`define PCS_ERR_CNT_W 8

`endif

// ==== design/pcs_hdr_pkg.sv ====
// Sync header type shared by the PCS receive status blocks
`include "pcs_rx_consts.svh"

package pcs_hdr_pkg;

    // Only these two codes are legal, 2'b00 and 2'b11 count as invalid headers
    typedef enum logic [`PCS_HDR_W-1:0] {
        SYNC_DATA = `PCS_SYNC_DATA,
        SYNC_CTRL = `PCS_SYNC_CTRL
    } sync_hdr_t;

endpackage

// ==== design/pcs_lock_pkg.sv ====
// Block lock state encoding for the PCS receive path
package pcs_lock_pkg;

    // Hunting for header alignment, or aligned and monitoring
    typedef enum logic {
        LOCK_HUNT   = 1'b0,
        LOCK_LOCKED = 1'b1
    } lock_state_t;

endpackage

// ==== design/pcs_rx_block_lock.sv ====
// Block lock FSM that tracks sync header validity and requests gearbox bit slips
`timescale 1ns/100ps
`include "pcs_rx_consts.svh"

module pcs_rx_block_lock
    import pcs_hdr_pkg::*;
    import pcs_lock_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  sync_hdr_t serdes_rx_hdr,
    output logic      rx_block_lock,
    output logic      rx_bitslip
);

    localparam int GOOD_W = $clog2(`PCS_LOCK_GOOD_CNT);
    localparam int WIN_W = $clog2(`PCS_LOCK_WINDOW);
    localparam int BAD_W = $clog2(`PCS_LOCK_BAD_MAX);

    // Terminal values, reached on the last header of each count
    localparam logic [GOOD_W-1:0] GOOD_LAST = GOOD_W'(`PCS_LOCK_GOOD_CNT - 1);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`PCS_LOCK_WINDOW - 1);
    localparam logic [BAD_W-1:0] BAD_LAST = BAD_W'(`PCS_LOCK_BAD_MAX - 1);

    lock_state_t       state_reg;
    lock_state_t       state_next;
    logic [GOOD_W-1:0] good_cnt_reg;
    logic [GOOD_W-1:0] good_cnt_next;
    logic [WIN_W-1:0]  win_cnt_reg;
    logic [WIN_W-1:0]  win_cnt_next;
    logic [BAD_W-1:0]  bad_cnt_reg;
    logic [BAD_W-1:0]  bad_cnt_next;
    logic              slip_reg;
    logic              slip_next;
    logic              hdr_valid;

    assign hdr_valid = (serdes_rx_hdr == SYNC_DATA) || (serdes_rx_hdr == SYNC_CTRL);

    // Lock is a direct decode of the state register
    assign rx_block_lock = (state_reg == LOCK_LOCKED);
    assign rx_bitslip = slip_reg;

    always_comb begin
        state_next = state_reg;
        good_cnt_next = good_cnt_reg;
        win_cnt_next = win_cnt_reg;
        bad_cnt_next = bad_cnt_reg;
        slip_next = 1'b0;

        case (state_reg)
            LOCK_HUNT: begin
                if (hdr_valid) begin
                    if (good_cnt_reg == GOOD_LAST) begin
                        state_next = LOCK_LOCKED;
                        good_cnt_next = '0;
                        win_cnt_next = '0;
                        bad_cnt_next = '0;
                    end else begin
                        good_cnt_next = good_cnt_reg + 1'b1;
                    end
                end else begin
                    good_cnt_next = '0;
                    // The gearbox takes a cycle to apply a slip, so back-to-back
                    // invalid headers yield one pulse every other cycle
                    slip_next = !slip_reg;
                end
            end
            LOCK_LOCKED: begin
                if (!hdr_valid && bad_cnt_reg == BAD_LAST) begin
                    // Too many errors in this window, give up alignment
                    state_next = LOCK_HUNT;
                    win_cnt_next = '0;
                    bad_cnt_next = '0;
                    slip_next = 1'b1;
                end else if (win_cnt_reg == WIN_LAST) begin
                    win_cnt_next = '0;
                    bad_cnt_next = '0;
                end else begin
                    win_cnt_next = win_cnt_reg + 1'b1;
                    if (!hdr_valid) begin
                        bad_cnt_next = bad_cnt_reg + 1'b1;
                    end
                end
            end
            default: begin
                state_next = LOCK_HUNT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= LOCK_HUNT;
            good_cnt_reg <= '0;
            win_cnt_reg <= '0;
            bad_cnt_reg <= '0;
            slip_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            good_cnt_reg <= good_cnt_next;
            win_cnt_reg <= win_cnt_next;
            bad_cnt_reg <= bad_cnt_next;
            slip_reg <= slip_next;
        end
    end

endmodule

// ==== design/pcs_rx_ber_mon.sv ====
// BER monitor that flags high bit error rate from invalid headers per timer window
`timescale 1ns/100ps
`include "pcs_rx_consts.svh"

module pcs_rx_ber_mon
    import pcs_hdr_pkg::*;
#(
    parameter int BER_WINDOW = `PCS_BER_WINDOW_DEFAULT
) (
    input  logic      clk,
    input  logic      rst,
    input  sync_hdr_t serdes_rx_hdr,
    output logic      rx_high_ber
);

    localparam int TIMER_W = $clog2(BER_WINDOW + 1);
    localparam logic [TIMER_W-1:0] TIMER_LOAD = TIMER_W'(BER_WINDOW);
    localparam int BAD_W = $clog2(`PCS_BER_BAD_MAX);
    localparam logic [BAD_W-1:0] BAD_SAT = BAD_W'(`PCS_BER_BAD_MAX - 1);

    logic [TIMER_W-1:0] timer_reg;
    logic [TIMER_W-1:0] timer_next;
    logic [BAD_W-1:0]   bad_cnt_reg;
    logic [BAD_W-1:0]   bad_cnt_next;
    logic               high_ber_reg;
    logic               high_ber_next;
    logic               hdr_valid;
    logic               expire;

    assign hdr_valid = (serdes_rx_hdr == SYNC_DATA) || (serdes_rx_hdr == SYNC_CTRL);
    assign expire = (timer_reg == '0);
    assign rx_high_ber = high_ber_reg;

    always_comb begin
        timer_next = timer_reg - 1'b1;
        bad_cnt_next = bad_cnt_reg;
        high_ber_next = high_ber_reg;

        if (bad_cnt_reg == BAD_SAT) begin
            // A 16th error sets the flag, and a saturated window never clears it
            if (!hdr_valid) begin
                high_ber_next = 1'b1;
            end
        end else begin
            if (!hdr_valid) begin
                bad_cnt_next = bad_cnt_reg + 1'b1;
            end
            if (expire) begin
                high_ber_next = 1'b0;
            end
        end

        // Window boundary restarts the tally regardless of the header
        if (expire) begin
            timer_next = TIMER_LOAD;
            bad_cnt_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_reg <= TIMER_LOAD;
            bad_cnt_reg <= '0;
            high_ber_reg <= 1'b0;
        end else begin
            timer_reg <= timer_next;
            bad_cnt_reg <= bad_cnt_next;
            high_ber_reg <= high_ber_next;
        end
    end

endmodule

// ==== design/pcs_rx_err_count.sv ====
// Saturating count of invalid sync headers received while block lock is held
`timescale 1ns/100ps
`include "pcs_rx_consts.svh"

module pcs_rx_err_count
    import pcs_hdr_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  sync_hdr_t                 serdes_rx_hdr,
    input  logic                      rx_block_lock,
    input  logic                      err_clear,
    output logic [`PCS_ERR_CNT_W-1:0] err_block_count
);

    logic [`PCS_ERR_CNT_W-1:0] count_reg;
    logic                      hdr_valid;
    logic                      count_inc;

    assign hdr_valid = (serdes_rx_hdr == SYNC_DATA) || (serdes_rx_hdr == SYNC_CTRL);

    // Errors before lock only reflect misalignment, so they are not counted
    assign count_inc = rx_block_lock && !hdr_valid;

    assign err_block_count = count_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_reg <= '0;
        end else if (err_clear) begin
            count_reg <= '0;
        end else if (count_inc && count_reg != '1) begin
            // Hold at all ones so a status read never sees a wrapped value
            count_reg <= count_reg + 1'b1;
        end
    end

endmodule

// ==== design/pcs_rx_status.sv ====
// PCS receive status top joining block lock, BER monitor and error counter
`timescale 1ns/100ps
`include "pcs_rx_consts.svh"

module pcs_rx_status
    import pcs_hdr_pkg::*;
#(
    parameter int BER_WINDOW = `PCS_BER_WINDOW_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  sync_hdr_t                 serdes_rx_hdr,
    input  logic                      err_clear,
    output logic                      rx_bitslip,
    output logic                      rx_block_lock,
    output logic                      rx_high_ber,
    output logic [`PCS_ERR_CNT_W-1:0] err_block_count
);

    pcs_rx_block_lock block_lock_inst (
        .clk           (clk),
        .rst           (rst),
        .serdes_rx_hdr (serdes_rx_hdr),
        .rx_block_lock (rx_block_lock),
        .rx_bitslip    (rx_bitslip)
    );

    pcs_rx_ber_mon #(
        .BER_WINDOW (BER_WINDOW)
    ) ber_mon_inst (
        .clk           (clk),
        .rst           (rst),
        .serdes_rx_hdr (serdes_rx_hdr),
        .rx_high_ber   (rx_high_ber)
    );

    // Lock gates the error count so only post-alignment errors are tallied
    pcs_rx_err_count err_count_inst (
        .clk             (clk),
        .rst             (rst),
        .serdes_rx_hdr   (serdes_rx_hdr),
        .rx_block_lock   (rx_block_lock),
        .err_clear       (err_clear),
        .err_block_count (err_block_count)
    );

endmodule

// ==== sim/pcs_rx_status_assert.sv ====
// Bound checker on the PCS receive status outputs and the block lock state
`timescale 1ns/100ps
`include "pcs_rx_consts.svh"

module pcs_rx_status_assert
    import pcs_lock_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input logic                      err_clear,
    input logic                      rx_bitslip,
    input logic                      rx_block_lock,
    input logic                      rx_high_ber,
    input logic [`PCS_ERR_CNT_W-1:0] err_block_count,
    input lock_state_t               lock_state
);

    int unsigned fail_count = 0;

    // The gearbox needs a cycle to act on each slip
    slip_single: assert property (@(posedge clk) disable iff (rst)
        rx_bitslip |=> !rx_bitslip)
        else begin
            $error("rx_bitslip high on two consecutive cycles");
            fail_count++;
        end

    slip_unlocked: assert property (@(posedge clk) disable iff (rst)
        rx_block_lock |=> !(rx_block_lock && rx_bitslip))
        else begin
            $error("rx_bitslip pulsed while block lock was held");
            fail_count++;
        end

    reset_outputs: assert property (@(posedge clk)
        rst |=> (!rx_bitslip && !rx_block_lock && !rx_high_ber && err_block_count == '0))
        else begin
            $error("outputs not cleared by reset");
            fail_count++;
        end

    count_monotonic: assert property (@(posedge clk) disable iff (rst)
        !err_clear |=> (err_block_count >= $past(err_block_count)))
        else begin
            $error("err_block_count decreased without err_clear");
            fail_count++;
        end

    // Dropping out of lock must come with a slip request to the gearbox
    lock_loss_slip: assert property (@(posedge clk) disable iff (rst)
        (lock_state == LOCK_HUNT && $past(lock_state) == LOCK_LOCKED) |-> rx_bitslip)
        else begin
            $error("block lock was lost without a bit slip request");
            fail_count++;
        end

endmodule

// ==== sim/pcs_rx_status_tb.sv ====
// Testbench for the PCS receive status block, checked against a cycle-accurate reference model
`timescale 1ns/100ps
`include "pcs_rx_consts.svh"

module pcs_rx_status_tb
    import pcs_hdr_pkg::*;
    import pcs_lock_pkg::*;
();

    localparam int BER_WIN = 200;
    localparam int ERR_MAX = (1 << `PCS_ERR_CNT_W) - 1;
    // All tests together run for roughly 2300 cycles
    localparam int TEST_CYCLES = 3000;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    typedef struct packed {
        lock_state_t lock_state;
        int          good_cnt;
        int          win_cnt;
        int          lock_bad;
        logic        slip;
        int          ber_timer;
        int          ber_bad;
        logic        high_ber;
        int          err_cnt;
    } model_t;

    logic                      clk;
    logic                      rst;
    sync_hdr_t                 serdes_rx_hdr;
    logic                      err_clear;
    logic                      rx_bitslip;
    logic                      rx_block_lock;
    logic                      rx_high_ber;
    logic [`PCS_ERR_CNT_W-1:0] err_block_count;

    model_t model;
    string  test_name;
    logic   checking;
    int     cycle_count;
    bit     bad_slot [0:255];

    pcs_rx_status #(
        .BER_WINDOW (BER_WIN)
    ) pcs_rx_status_inst (
        .clk             (clk),
        .rst             (rst),
        .serdes_rx_hdr   (serdes_rx_hdr),
        .err_clear       (err_clear),
        .rx_bitslip      (rx_bitslip),
        .rx_block_lock   (rx_block_lock),
        .rx_high_ber     (rx_high_ber),
        .err_block_count (err_block_count)
    );

    bind pcs_rx_status pcs_rx_status_assert assert_inst (
        .clk             (clk),
        .rst             (rst),
        .err_clear       (err_clear),
        .rx_bitslip      (rx_bitslip),
        .rx_block_lock   (rx_block_lock),
        .rx_high_ber     (rx_high_ber),
        .err_block_count (err_block_count),
        .lock_state      (block_lock_inst.state_reg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic is_valid(input sync_hdr_t h);
        return (h == SYNC_DATA) || (h == SYNC_CTRL);
    endfunction

    function automatic model_t model_reset();
        model_t m;
        m = '0;
        m.lock_state = LOCK_HUNT;
        m.ber_timer = BER_WIN;
        return m;
    endfunction

    // One clock of the whole receive status path, outputs are read from the returned state
    function automatic model_t model_step(input model_t cur, input sync_hdr_t h, input logic clr);
        model_t nxt;
        logic   ok;
        nxt = cur;
        ok = is_valid(h);
        nxt.slip = 1'b0;

        // The error counter sees the lock level that was registered before this edge
        if (clr) begin
            nxt.err_cnt = 0;
        end else if (cur.lock_state == LOCK_LOCKED && !ok && cur.err_cnt < ERR_MAX) begin
            nxt.err_cnt = cur.err_cnt + 1;
        end

        if (cur.lock_state == LOCK_HUNT) begin
            if (!ok) begin
                nxt.good_cnt = 0;
                nxt.slip = !cur.slip;
            end else if (cur.good_cnt == `PCS_LOCK_GOOD_CNT - 1) begin
                nxt.lock_state = LOCK_LOCKED;
                nxt.good_cnt = 0;
                nxt.win_cnt = 0;
                nxt.lock_bad = 0;
            end else begin
                nxt.good_cnt = cur.good_cnt + 1;
            end
        end else if (!ok && cur.lock_bad == `PCS_LOCK_BAD_MAX - 1) begin
            nxt.lock_state = LOCK_HUNT;
            nxt.win_cnt = 0;
            nxt.lock_bad = 0;
            nxt.slip = 1'b1;
        end else if (cur.win_cnt == `PCS_LOCK_WINDOW - 1) begin
            // Last slot of the window only restarts it
            nxt.win_cnt = 0;
            nxt.lock_bad = 0;
        end else begin
            nxt.win_cnt = cur.win_cnt + 1;
            nxt.lock_bad = cur.lock_bad + (ok ? 0 : 1);
        end

        if (!ok && cur.ber_bad == `PCS_BER_BAD_MAX - 1) begin
            nxt.high_ber = 1'b1;
        end else if (!ok) begin
            nxt.ber_bad = cur.ber_bad + 1;
        end
        if (cur.ber_timer == 0) begin
            if (cur.ber_bad != `PCS_BER_BAD_MAX - 1) begin
                nxt.high_ber = 1'b0;
            end
            nxt.ber_timer = BER_WIN;
            nxt.ber_bad = 0;
        end else begin
            nxt.ber_timer = cur.ber_timer - 1;
        end
        return nxt;
    endfunction

    task automatic fail_run();
        $display("Test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %0b actual %0b", test_name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_count(input string what, input logic [`PCS_ERR_CNT_W-1:0] exp,
                               input logic [`PCS_ERR_CNT_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %0d actual %0d", test_name, what, exp, act);
            fail_run();
        end
    endtask

    function automatic sync_hdr_t rand_valid();
        return ($urandom & 1) ? SYNC_CTRL : SYNC_DATA;
    endfunction

    function automatic sync_hdr_t rand_invalid();
        return ($urandom & 1) ? sync_hdr_t'(2'b11) : sync_hdr_t'(2'b00);
    endfunction

    // Marks count distinct random slots in 0 to len-1 as invalid
    task automatic pick_bad_slots(input int len, input int count);
        int placed;
        int idx;
        placed = 0;
        foreach (bad_slot[k]) bad_slot[k] = 1'b0;
        while (placed < count) begin
            idx = $urandom_range(len - 1, 0);
            if (!bad_slot[idx]) begin
                bad_slot[idx] = 1'b1;
                placed++;
            end
        end
    endtask

    task automatic send(input sync_hdr_t h, input logic clr);
        serdes_rx_hdr = h;
        err_clear = clr;
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            model <= model_reset();
        end else begin
            model <= model_step(model, serdes_rx_hdr, err_clear);
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_flag("rx_block_lock", model.lock_state == LOCK_LOCKED, rx_block_lock);
            check_flag("rx_high_ber", model.high_ber, rx_high_ber);
            check_flag("rx_bitslip", model.slip, rx_bitslip);
            check_count("err_block_count", `PCS_ERR_CNT_W'(model.err_cnt), err_block_count);
        end
    end

    always @(negedge clk) begin
        if (pcs_rx_status_inst.assert_inst.fail_count != 0) begin
            $display("An assertion in the bound checker failed");
            fail_run();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial begin
        int s;
        int n;
        rst = 1'b1;
        serdes_rx_hdr = SYNC_DATA;
        err_clear = 1'b0;
        checking = 1'b0;
        cycle_count = 0;
        test_name = "reset";
        void'($urandom(32'hb143_acdf));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        checking = 1'b1;

        test_name = "lock_acq";
        repeat (`PCS_LOCK_GOOD_CNT - 1) send(rand_valid(), 1'b0);
        check_flag("lock after 63 valid", 1'b0, rx_block_lock);
        send(rand_valid(), 1'b0);
        check_flag("lock after 64 valid", 1'b1, rx_block_lock);

        // The lock window starts right after lock, so slot 63 stays valid here
        test_name = "lock_loss";
        pick_bad_slots(`PCS_LOCK_WINDOW - 1, `PCS_LOCK_BAD_MAX - 1);
        for (s = 0; s < `PCS_LOCK_WINDOW; s++) begin
            send(bad_slot[s] ? rand_invalid() : rand_valid(), 1'b0);
        end
        check_flag("lock after 15 invalid", 1'b1, rx_block_lock);
        pick_bad_slots(`PCS_LOCK_WINDOW - 1, `PCS_LOCK_BAD_MAX);
        s = 0;
        n = 0;
        while (n < `PCS_LOCK_BAD_MAX) begin
            n += bad_slot[s] ? 1 : 0;
            send(bad_slot[s] ? rand_invalid() : rand_valid(), 1'b0);
            s++;
        end
        check_flag("lock after 16 invalid", 1'b0, rx_block_lock);
        check_flag("slip on lock loss", 1'b1, rx_bitslip);

        test_name = "hunt_slip";
        repeat (20) send(rand_valid(), 1'b0);
        send(rand_invalid(), 1'b0);
        check_flag("slip on hunt error", 1'b1, rx_bitslip);
        repeat (5) send(rand_invalid(), 1'b0);
        repeat (`PCS_LOCK_GOOD_CNT - 1) send(rand_valid(), 1'b0);
        check_flag("lock after 63 fresh valid", 1'b0, rx_block_lock);
        send(rand_valid(), 1'b0);
        check_flag("lock after 64 fresh valid", 1'b1, rx_block_lock);

        // 14 early errors plus one in the last slot keep lock, 15 errors per window
        test_name = "err_count";
        for (n = 0; n < 19; n++) begin
            for (s = 0; s < `PCS_LOCK_WINDOW; s++) begin
                send((s < 14 || s == `PCS_LOCK_WINDOW - 1) ? rand_invalid() : rand_valid(),
                     n == 0 && s == 0);
                if (n == 0 && s == 0) begin
                    check_count("clear with invalid header", '0, err_block_count);
                end
            end
        end
        check_flag("lock held through bursts", 1'b1, rx_block_lock);
        check_count("saturated count", ERR_MAX, err_block_count);
        send(rand_invalid(), 1'b1);
        check_count("clear at saturation", '0, err_block_count);
        send(rand_invalid(), 1'b0);
        check_count("count after clear", 1, err_block_count);

        test_name = "high_ber";
        while (model.ber_timer != BER_WIN) send(rand_valid(), 1'b0);
        repeat (BER_WIN + 1) send(rand_valid(), 1'b0);
        check_flag("flag after clean window", 1'b0, rx_high_ber);
        pick_bad_slots(BER_WIN, `PCS_BER_BAD_MAX);
        for (s = 0; s <= BER_WIN; s++) begin
            send(bad_slot[s] ? rand_invalid() : rand_valid(), 1'b0);
        end
        check_flag("flag after 16 invalid", 1'b1, rx_high_ber);
        pick_bad_slots(BER_WIN + 1, 10);
        for (s = 0; s <= BER_WIN; s++) begin
            send(bad_slot[s] ? rand_invalid() : rand_valid(), 1'b0);
        end
        check_flag("flag after quiet window", 1'b0, rx_high_ber);

        repeat (2) send(rand_valid(), 1'b0);
        if (pcs_rx_status_inst.assert_inst.fail_count != 0) begin
            $display("%0d assertion failures", pcs_rx_status_inst.assert_inst.fail_count);
            fail_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== pcs_rx_status.f ====
+incdir+design
design/pcs_hdr_pkg.sv
design/pcs_lock_pkg.sv
design/pcs_rx_block_lock.sv
design/pcs_rx_ber_mon.sv
design/pcs_rx_err_count.sv
design/pcs_rx_status.sv
sim/pcs_rx_status_assert.sv
sim/pcs_rx_status_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := pcs_rx_status_tb
RTL_TOP    := pcs_rx_status
FILELIST   := pcs_rx_status.f
LINT_FLAGS := --lint-only -Wall --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP)
SIM_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failed
PASS_MSG   := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without passing"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
